//--- tb.f
verilog/ll_pkg.sv
verilog/link_online_delay.sv
verilog/st_packer.sv
verilog/ll_transmit.sv
verilog/phy_framer.sv
verilog/st_link_master_top.sv
tests/st_link_master_assertions.sv
tests/tb_st_link_master.sv

//--- Bender.yml
package:
  name: st_link_master

sources:
  - verilog/ll_pkg.sv
  - verilog/link_online_delay.sv
  - verilog/st_packer.sv
  - verilog/ll_transmit.sv
  - verilog/phy_framer.sv
  - verilog/st_link_master_top.sv
  - target: test
    files:
      - tests/st_link_master_assertions.sv
      - tests/tb_st_link_master.sv

//--- tests/tb_st_link_master.sv
`default_nettype none

module tb_st_link_master;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT       = 2000;
  localparam int FIFO_DEPTH    = 4;
  localparam int PUSH_LANE_BIT = ll_pkg::PUSH_BIT - ll_pkg::LANE_PAYLOAD_W;
  localparam int PL            = ll_pkg::LANE_PAYLOAD_W;

  logic                        clk_wr;
  logic                        arst_n;
  logic                        tx_online;
  logic                        rx_online;
  logic                        gen2_mode;
  logic [ll_pkg::CREDIT_W-1:0] init_credit;
  logic [15:0]                 delay_value;
  logic [ll_pkg::DATA_W-1:0]   user_tdata;
  logic [ll_pkg::KEEP_W-1:0]   user_tkeep;
  logic                        user_tlast;
  logic                        user_tvalid;
  logic                        user_tready;
  logic [ll_pkg::LANE_W-1:0]   tx_phy0;
  logic [ll_pkg::LANE_W-1:0]   tx_phy1;
  logic [ll_pkg::LANE_W-1:0]   rx_phy0 = '0;
  // Receive lane 1 unused in this direction
  logic [ll_pkg::LANE_W-1:0]   rx_phy1 = '0;
  logic [ll_pkg::DBG_W-1:0]    debug_status;

  // Scoreboard and receiver state
  logic [ll_pkg::WORD_W-1:0]   exp_q[$];
  int                          credit_due[$];
  int                          held_credits = 0;
  bit                          hold_credit = 1'b0;
  bit                          send_done = 1'b0;
  int                          cycle_cnt = 0;
  int                          rx_words = 0;
  int                          err_cnt = 0;
  logic [31:0]                 lcg_state = 32'd52;
  logic [PL-1:0]               prev_lo = '0;
  logic                        prev_stb = 1'b0;

  st_link_master_top #(
    .FIFO_DEPTH     (FIFO_DEPTH),
    .DEFAULT_CREDIT (8'd8)
  ) i_dut (
    .clk_wr       (clk_wr),
    .arst_n       (arst_n),
    .tx_online    (tx_online),
    .rx_online    (rx_online),
    .gen2_mode    (gen2_mode),
    .init_credit  (init_credit),
    .delay_value  (delay_value),
    .user_tdata   (user_tdata),
    .user_tkeep   (user_tkeep),
    .user_tlast   (user_tlast),
    .user_tvalid  (user_tvalid),
    .user_tready  (user_tready),
    .tx_phy0      (tx_phy0),
    .tx_phy1      (tx_phy1),
    .rx_phy0      (rx_phy0),
    .rx_phy1      (rx_phy1),
    .debug_status (debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected link word, bytes without keep read as zero
  function automatic logic [ll_pkg::WORD_W-1:0] expect_word(
    input logic [ll_pkg::DATA_W-1:0] data,
    input logic [ll_pkg::KEEP_W-1:0] keep,
    input logic                      last
  );
    logic [ll_pkg::DATA_W-1:0] mask;
    mask = '0;
    for (int b = 0; b < ll_pkg::KEEP_W; b++) begin
      if (keep[b]) mask[8*b +: 8] = 8'hff;
    end
    return {last, keep, data & mask};
  endfunction

  task automatic finish_run();
    int assert_fails;
    assert_fails = i_dut.i_assertions.fail_cnt;
    $display("errors: scoreboard %0d, assertions %0d", err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    err_cnt++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("FAILED %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic drive_random_beat();
    logic [31:0] r;
    r = next_rand();
    user_tdata  <= {next_rand(), next_rand()};
    user_tkeep  <= r[31:24];
    user_tlast  <= r[23];
    user_tvalid <= 1'b1;
  endtask

  // Compare one decoded word and schedule its credit return
  task automatic check_word(input logic [ll_pkg::WORD_W-1:0] got);
    logic [ll_pkg::WORD_W-1:0] expected;
    if (exp_q.size() == 0) begin
      err_cnt++;
      $display("word arrived on the PHY with none outstanding");
    end else begin
      expected = exp_q.pop_front();
      check_value("tdata", expected[63:0], got[63:0]);
      check_value("tkeep", expected[71:64], got[71:64]);
      check_value("tlast", expected[72], got[72]);
    end
    rx_words++;
    if (hold_credit) begin
      held_credits++;
    end else begin
      credit_due.push_back(cycle_cnt + 1 + int'((next_rand() >> 16) % 6));
    end
  endtask

  //////////////////////////////
  // Lane receiver model
  //////////////////////////////
  always @(posedge clk_wr) begin : receiver
    int                             found;
    logic [ll_pkg::PAYLOAD_W-1:0] payload;
    if (!arst_n) begin
      rx_phy0 <= '0;
    end else begin
      cycle_cnt++;
      // One credit pulse per cycle, oldest due first
      found = -1;
      foreach (credit_due[i]) begin
        if (found < 0 && credit_due[i] <= cycle_cnt) found = i;
      end
      if (found >= 0) begin
        credit_due.delete(found);
        rx_phy0 <= ll_pkg::LANE_W'(1) << ll_pkg::CREDIT_BIT;
      end else begin
        rx_phy0 <= '0;
      end
      if (gen2_mode) begin
        if (tx_phy0[ll_pkg::MRK_BIT] || tx_phy1[ll_pkg::MRK_BIT]) begin
          payload = {tx_phy1[PL-1:0], tx_phy0[PL-1:0]};
          check_value("tx_phy0[39:38]", 2'b11, tx_phy0[39:38]);
          check_value("tx_phy1[39:38]", 2'b11, tx_phy1[39:38]);
          check_value("pushbit", 1'b1, tx_phy1[PUSH_LANE_BIT]);
          check_word(payload[ll_pkg::WORD_W-1:0]);
        end
      end else begin
        // Marker high closes a word, low half was the beat before
        if (tx_phy0[ll_pkg::MRK_BIT]) begin
          payload = {tx_phy0[PL-1:0], prev_lo};
          check_value("tx_phy0 strobe pair", 2'b11, {prev_stb, tx_phy0[ll_pkg::STB_BIT]});
          check_value("pushbit", 1'b1, payload[ll_pkg::PUSH_BIT]);
          check_value("tx_phy1", '0, tx_phy1);
          check_word(payload[ll_pkg::WORD_W-1:0]);
        end
        prev_lo  = tx_phy0[PL-1:0];
        prev_stb = tx_phy0[ll_pkg::STB_BIT];
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////
  task automatic send_beats(input int count);
    int sent;
    int waited;
    sent   = 0;
    waited = 0;
    @(posedge clk_wr);
    drive_random_beat();
    while (sent < count) begin
      @(posedge clk_wr);
      if (user_tvalid && user_tready) begin
        exp_q.push_back(expect_word(user_tdata, user_tkeep, user_tlast));
        sent++;
        waited = 0;
        if (sent < count) drive_random_beat();
        else user_tvalid <= 1'b0;
      end else if (waited == TIMEOUT) begin
        timeout_abort("user_tready on a pending beat");
      end else begin
        waited++;
      end
    end
  endtask

  task automatic bring_link_up(input logic gen2, input logic [ll_pkg::CREDIT_W-1:0] credit);
    int waited;
    waited = 0;
    @(posedge clk_wr);
    gen2_mode   <= gen2;
    init_credit <= credit;
    delay_value <= 16'd5;
    tx_online   <= 1'b1;
    repeat (2) @(posedge clk_wr);
    rx_online <= 1'b1;
    while (!debug_status[ll_pkg::DBG_LINK_UP_BIT]) begin
      if (waited == TIMEOUT) timeout_abort("link-up");
      @(posedge clk_wr);
      waited++;
    end
  endtask

  task automatic take_link_down();
    int waited;
    waited = 0;
    // Let the last credit pulse reach the counter
    repeat (4) @(posedge clk_wr);
    tx_online <= 1'b0;
    rx_online <= 1'b0;
    while (debug_status[ll_pkg::DBG_LINK_UP_BIT]) begin
      if (waited == TIMEOUT) timeout_abort("link-down");
      @(posedge clk_wr);
      waited++;
    end
    repeat (3) @(posedge clk_wr);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || credit_due.size() != 0 || held_credits != 0) begin
      if (waited == TIMEOUT) timeout_abort("all words and credits to drain");
      @(posedge clk_wr);
      waited++;
    end
  endtask

  task automatic wait_backpressure();
    int waited;
    waited = 0;
    while (!(user_tvalid && !user_tready)) begin
      if (waited == TIMEOUT) timeout_abort("user_tready to fall with no credit");
      @(posedge clk_wr);
      waited++;
    end
  endtask

  task automatic wait_send_done();
    int waited;
    waited = 0;
    while (!send_done) begin
      if (waited == TIMEOUT) timeout_abort("the last beat to be accepted");
      @(posedge clk_wr);
      waited++;
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int start_words;
    arst_n      = 1'b0;
    tx_online   = 1'b0;
    rx_online   = 1'b0;
    gen2_mode   = 1'b1;
    init_credit = '0;
    delay_value = 16'd5;
    user_tdata  = '0;
    user_tkeep  = '0;
    user_tlast  = 1'b0;
    user_tvalid = 1'b0;
    repeat (4) @(posedge clk_wr);
    arst_n <= 1'b1;
    repeat (3) @(posedge clk_wr);

    // Gen2 at the default credit
    bring_link_up(1'b1, 8'd0);
    send_beats(40);
    wait_drained();
    take_link_down();

    // Words parked in the FIFO while the link is down
    send_beats(3);
    // Gen1, two beats per word on lane 0
    bring_link_up(1'b0, 8'd0);
    send_beats(30);
    wait_drained();
    take_link_down();

    // Two credits, returns withheld until the FIFO backs up
    bring_link_up(1'b1, 8'd2);
    hold_credit = 1'b1;
    start_words = rx_words;
    fork
      begin
        send_beats(12);
        send_done = 1'b1;
      end
    join_none
    wait_backpressure();
    repeat (10) @(posedge clk_wr);
    check_value("words_on_two_credits", 2, rx_words - start_words);
    // Full FIFO plus the packer register
    check_value("words_held_in_dut", FIFO_DEPTH + 1, exp_q.size());
    hold_credit = 1'b0;
    while (held_credits > 0) begin
      credit_due.push_back(cycle_cnt + 1 + int'((next_rand() >> 16) % 6));
      held_credits--;
    end
    wait_send_done();
    wait_drained();
    finish_run();
  end

endmodule

`default_nettype wire

//--- tests/st_link_master_assertions.sv
`default_nettype none

// Protocol checks on the link master, bound into the top level
module st_link_master_assertions #(
  parameter logic [ll_pkg::CREDIT_W-1:0] DEFAULT_CREDIT = 8
) (
  input  logic                        clk_wr,
  input  logic                        arst_n,
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic                        gen2_mode,
  input  logic [ll_pkg::CREDIT_W-1:0] init_credit,
  input  logic [15:0]                 delay_value,
  input  logic [ll_pkg::LANE_W-1:0]   tx_phy0,
  input  logic [ll_pkg::LANE_W-1:0]   tx_phy1,
  input  logic [ll_pkg::DBG_W-1:0]    debug_status,
  input  logic                        tx_push,
  input  logic                        rx_credit
);

  timeunit 1ns;
  timeprecision 1ps;

  // Pushbit position once the payload is split into lanes
  localparam int PUSH_LANE_BIT = ll_pkg::PUSH_BIT - ll_pkg::LANE_PAYLOAD_W;

  int                          fail_cnt = 0;
  logic                        link;
  logic                        link_q;
  logic                        link_seen;
  logic [ll_pkg::CREDIT_W-1:0] loaded;
  logic [ll_pkg::CREDIT_W-1:0] outstanding;

  // Link state as seen on the status word
  assign link = debug_status[ll_pkg::DBG_LINK_UP_BIT];

  //////////////////////////////
  // Credit bookkeeping
  //////////////////////////////
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_q      <= 1'b0;
      link_seen   <= 1'b0;
      loaded      <= '0;
      outstanding <= '0;
    end else begin
      link_q <= link;
      if (link) begin
        link_seen <= 1'b1;
      end
      if (!link) begin
        outstanding <= '0;
      end else if (!link_q) begin
        // Fresh link, zero request means the default
        loaded      <= (init_credit == '0) ? DEFAULT_CREDIT : init_credit;
        outstanding <= '0;
      end else begin
        // Pushes still waiting for their credit to come back
        outstanding <= outstanding + ll_pkg::CREDIT_W'(tx_push)
                                   - ll_pkg::CREDIT_W'(rx_credit);
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Nothing moves until the first link-up
  a_quiet_before_link: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (!link_seen && !link) |-> tx_phy0 == '0 && tx_phy1 == '0 && debug_status == '0)
    else begin
      $error("lanes or status active before link-up");
      fail_cnt++;
    end

  // Lane beat with a pushbit, link must have been up the cycle before
  a_pushbit_needs_link: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (tx_phy1[PUSH_LANE_BIT] || (tx_phy0[ll_pkg::MRK_BIT] && tx_phy0[PUSH_LANE_BIT]))
    |-> $past(link))
    else begin
      $error("pushbit on the lanes while the link is down");
      fail_cnt++;
    end

  // Six edges with both online, then up
  a_link_delay: assert property (@(posedge clk_wr) disable iff (!arst_n)
    ($rose(tx_online && rx_online) && delay_value == 16'd5)
    |-> !link [*7] ##1 link)
    else begin
      $error("link-up did not follow the hold-off delay");
      fail_cnt++;
    end

  a_gen1_lane1_idle: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (!gen2_mode && !$past(gen2_mode)) |-> tx_phy1 == '0)
    else begin
      $error("lane 1 active in gen1 mode");
      fail_cnt++;
    end

  a_credit_bound: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (link && link_q) |-> outstanding <= loaded)
    else begin
      $error("more words pushed than credit allows");
      fail_cnt++;
    end

  a_credit_field: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (link && link_q)
    |-> debug_status[ll_pkg::DBG_CREDIT_LSB +: ll_pkg::CREDIT_W] == loaded - outstanding)
    else begin
      $error("status credit field off from loaded minus outstanding");
      fail_cnt++;
    end

endmodule

bind st_link_master_top st_link_master_assertions #(
  .DEFAULT_CREDIT (DEFAULT_CREDIT)
) i_assertions (
  .clk_wr       (clk_wr),
  .arst_n       (arst_n),
  .tx_online    (tx_online),
  .rx_online    (rx_online),
  .gen2_mode    (gen2_mode),
  .init_credit  (init_credit),
  .delay_value  (delay_value),
  .tx_phy0      (tx_phy0),
  .tx_phy1      (tx_phy1),
  .debug_status (debug_status),
  .tx_push      (tx_push),
  .rx_credit    (rx_credit)
);

`default_nettype wire

//--- verilog/st_link_master_top.sv
`default_nettype none

// Transmit side of the stream link
// Packer, credit FIFO and framer behind one link-up qualifier
module st_link_master_top #(
  parameter int                          FIFO_DEPTH     = 4,
  parameter logic [ll_pkg::CREDIT_W-1:0] DEFAULT_CREDIT = 8
) (
  input  logic                        clk_wr,
  input  logic                        arst_n,

  // Control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic                        gen2_mode,
  input  logic [ll_pkg::CREDIT_W-1:0] init_credit,
  input  logic [15:0]                 delay_value,

  // User stream
  input  logic [ll_pkg::DATA_W-1:0]   user_tdata,
  input  logic [ll_pkg::KEEP_W-1:0]   user_tkeep,
  input  logic                        user_tlast,
  input  logic                        user_tvalid,
  output logic                        user_tready,

  // PHY lanes
  output logic [ll_pkg::LANE_W-1:0]   tx_phy0,
  output logic [ll_pkg::LANE_W-1:0]   tx_phy1,
  input  logic [ll_pkg::LANE_W-1:0]   rx_phy0,
  input  logic [ll_pkg::LANE_W-1:0]   rx_phy1,

  output logic [ll_pkg::DBG_W-1:0]    debug_status
);

  //////////////////////////////
  // Interconnect
  //////////////////////////////
  logic                      link_up;
  logic                      pk_valid;
  logic [ll_pkg::WORD_W-1:0] pk_word;
  logic                      pk_ready;
  logic                      tx_push;
  logic [ll_pkg::WORD_W-1:0] tx_word;
  logic                      frm_ready;
  logic                      rx_credit;

  // Link-up qualifier
  link_online_delay i_online_delay (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .tx_online   (tx_online),
    .rx_online   (rx_online),
    .delay_value (delay_value),
    .link_up     (link_up)
  );

  // Producer
  st_packer i_packer (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready),
    .pk_valid    (pk_valid),
    .pk_word     (pk_word),
    .pk_ready    (pk_ready)
  );

  // Buffer with credit
  ll_transmit #(
    .FIFO_DEPTH     (FIFO_DEPTH),
    .DEFAULT_CREDIT (DEFAULT_CREDIT)
  ) i_transmit (
    .clk_wr       (clk_wr),
    .arst_n       (arst_n),
    .link_up      (link_up),
    .init_credit  (init_credit),
    .pk_valid     (pk_valid),
    .pk_word      (pk_word),
    .pk_ready     (pk_ready),
    .tx_push      (tx_push),
    .tx_word      (tx_word),
    .frm_ready    (frm_ready),
    .rx_credit    (rx_credit),
    .debug_status (debug_status)
  );

  // Consumer, lane framing
  phy_framer i_framer (
    .clk_wr    (clk_wr),
    .arst_n    (arst_n),
    .link_up   (link_up),
    .gen2_mode (gen2_mode),
    .tx_push   (tx_push),
    .tx_word   (tx_word),
    .frm_ready (frm_ready),
    .tx_phy0   (tx_phy0),
    .tx_phy1   (tx_phy1),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .rx_credit (rx_credit)
  );

endmodule

`default_nettype wire

//--- verilog/phy_framer.sv
`default_nettype none

// PHY framer
// Gen2 puts a word on both lanes in one beat
// Gen1 sends low half then high half on lane 0
module phy_framer (
  input  logic                      clk_wr,
  input  logic                      arst_n,
  input  logic                      link_up,
  input  logic                      gen2_mode,

  // From the transmit FIFO
  input  logic                      tx_push,
  input  logic [ll_pkg::WORD_W-1:0] tx_word,
  output logic                      frm_ready,

  // PHY lanes
  output logic [ll_pkg::LANE_W-1:0] tx_phy0,
  output logic [ll_pkg::LANE_W-1:0] tx_phy1,
  input  logic [ll_pkg::LANE_W-1:0] rx_phy0,
  // Lane 1 of the receive bus carries nothing for this direction
  input  logic [ll_pkg::LANE_W-1:0] rx_phy1,

  output logic                      rx_credit
);

  logic [ll_pkg::PAYLOAD_W-1:0]      payload;
  logic [ll_pkg::LANE_PAYLOAD_W-1:0] pay_lo;
  logic [ll_pkg::LANE_PAYLOAD_W-1:0] pay_hi;
  logic [ll_pkg::LANE_PAYLOAD_W-1:0] hi_hold;
  logic                              second_beat;
  logic [ll_pkg::LANE_W-1:0]         phy0_d;
  logic [ll_pkg::LANE_W-1:0]         phy1_d;

  // Word plus pushbit, all zero on idle cycles
  always_comb begin
    payload = '0;
    if (tx_push) begin
      payload[ll_pkg::WORD_W-1:0] = tx_word;
      payload[ll_pkg::PUSH_BIT]   = 1'b1;
    end
  end

  assign pay_lo = payload[ll_pkg::LANE_PAYLOAD_W-1:0];
  assign pay_hi = payload[ll_pkg::PAYLOAD_W-1 -: ll_pkg::LANE_PAYLOAD_W];

  // No new word while the gen1 high half is loading
  assign frm_ready = ~second_beat;

  //////////////////////////////
  // Gen1 beat state
  //////////////////////////////
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      second_beat <= 1'b0;
    end else begin
      second_beat <= tx_push & ~gen2_mode;
    end
  end

  // High half parked for the next gen1 beat
  always_ff @(posedge clk_wr) begin
    if (tx_push) begin
      hi_hold <= pay_hi;
    end
  end

  //////////////////////////////
  // Lane assembly
  //////////////////////////////
  always_comb begin
    phy0_d = '0;
    phy1_d = '0;
    // Strobe persists while the link is up
    phy0_d[ll_pkg::STB_BIT] = link_up;
    if (gen2_mode) begin
      phy1_d[ll_pkg::STB_BIT] = link_up;
      phy0_d[ll_pkg::MRK_BIT] = tx_push;
      phy1_d[ll_pkg::MRK_BIT] = tx_push;
      phy0_d[ll_pkg::LANE_PAYLOAD_W-1:0] = pay_lo;
      phy1_d[ll_pkg::LANE_PAYLOAD_W-1:0] = pay_hi;
    end else if (second_beat) begin
      // Marker high flags the upper half
      phy0_d[ll_pkg::MRK_BIT]            = 1'b1;
      phy0_d[ll_pkg::LANE_PAYLOAD_W-1:0] = hi_hold;
    end else begin
      phy0_d[ll_pkg::LANE_PAYLOAD_W-1:0] = pay_lo;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= phy0_d;
      tx_phy1 <= phy1_d;
    end
  end

  // Credit return, dropped while the link is down
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_credit <= 1'b0;
    end else begin
      rx_credit <= link_up & rx_phy0[ll_pkg::CREDIT_BIT];
    end
  end

endmodule

`default_nettype wire

//--- verilog/ll_transmit.sv
`default_nettype none

// Credit-gated transmit FIFO
// Words leave only with link up, credit left and the framer ready
module ll_transmit #(
  parameter int                            FIFO_DEPTH     = 4,
  parameter logic [ll_pkg::CREDIT_W-1:0]   DEFAULT_CREDIT = 8
) (
  input  logic                        clk_wr,
  input  logic                        arst_n,
  input  logic                        link_up,
  input  logic [ll_pkg::CREDIT_W-1:0] init_credit,

  // From the packer
  input  logic                        pk_valid,
  input  logic [ll_pkg::WORD_W-1:0]   pk_word,
  output logic                        pk_ready,

  // Toward the framer
  output logic                        tx_push,
  output logic [ll_pkg::WORD_W-1:0]   tx_word,
  input  logic                        frm_ready,
  input  logic                        rx_credit,

  output logic [ll_pkg::DBG_W-1:0]    debug_status
);

  localparam int               PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int               LVL_W    = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [LVL_W-1:0] FULL_LVL = LVL_W'(FIFO_DEPTH);

  logic [ll_pkg::WORD_W-1:0]   fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [LVL_W-1:0]            level;
  logic                        fifo_wr;
  logic                        fifo_empty;

  logic [ll_pkg::CREDIT_W-1:0] credit;
  logic [ll_pkg::CREDIT_W-1:0] load_credit;
  logic                        link_up_q;
  logic                        link_rise;

  //////////////////////////////
  // FIFO
  //////////////////////////////
  assign pk_ready   = level != FULL_LVL;
  assign fifo_wr    = pk_valid & pk_ready;
  assign fifo_empty = level == '0;

  // Pop gating
  assign tx_push = ~fifo_empty & (credit != '0) & link_up & frm_ready;
  // Head of the queue, valid whenever not empty
  assign tx_word = fifo_mem[rd_ptr];

  always_ff @(posedge clk_wr) begin
    if (fifo_wr) begin
      fifo_mem[wr_ptr] <= pk_word;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (tx_push) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Level tracks writes against pops
      case ({fifo_wr, tx_push})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  //////////////////////////////
  // Credit
  //////////////////////////////
  assign link_rise = link_up & ~link_up_q;
  // Zero from software means take the built-in default
  assign load_credit = (init_credit == '0) ? DEFAULT_CREDIT : init_credit;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_up_q <= 1'b0;
      credit    <= '0;
    end else begin
      link_up_q <= link_up;
      if (!link_up) begin
        credit <= '0;
      end else if (link_rise) begin
        credit <= load_credit;
      end else begin
        // Push and return in one cycle cancel out
        case ({rx_credit, tx_push})
          2'b10:   credit <= credit + 1'b1;
          2'b01:   credit <= credit - 1'b1;
          default: credit <= credit;
        endcase
      end
    end
  end

  // Status word, unused bits zero
  always_comb begin
    debug_status = '0;
    debug_status[ll_pkg::DBG_CREDIT_LSB +: ll_pkg::CREDIT_W] = credit;
    debug_status[ll_pkg::DBG_LEVEL_LSB +: LVL_W]             = level;
    debug_status[ll_pkg::DBG_LINK_UP_BIT]                    = link_up;
  end

endmodule

`default_nettype wire

//--- verilog/st_packer.sv
`default_nettype none

// Stream packer
// Masks data by keep, packs one beat into one link word
module st_packer (
  input  logic                      clk_wr,
  input  logic                      arst_n,

  // User stream
  input  logic [ll_pkg::DATA_W-1:0] user_tdata,
  input  logic [ll_pkg::KEEP_W-1:0] user_tkeep,
  input  logic                      user_tlast,
  input  logic                      user_tvalid,
  output logic                      user_tready,

  // Toward the transmit FIFO
  output logic                      pk_valid,
  output logic [ll_pkg::WORD_W-1:0] pk_word,
  input  logic                      pk_ready
);

  logic                      out_live;
  logic [ll_pkg::DATA_W-1:0] masked_data;
  logic                      accept;

  // Zero every byte whose keep bit is low
  always_comb begin
    for (int i = 0; i < ll_pkg::KEEP_W; i++) begin
      masked_data[8*i +: 8] = user_tkeep[i] ? user_tdata[8*i +: 8] : 8'h00;
    end
  end

  // Ready when the slot is free or drains this cycle
  // Held low for the first cycle out of reset
  assign user_tready = out_live & (~pk_valid | pk_ready);
  assign accept      = user_tvalid & user_tready;

  //////////////////////////////
  // Output slot
  //////////////////////////////
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      out_live <= 1'b0;
    end else begin
      out_live <= 1'b1;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      pk_valid <= 1'b0;
    end else if (accept) begin
      pk_valid <= 1'b1;
    end else if (pk_ready) begin
      // Word taken, nothing new behind it
      pk_valid <= 1'b0;
    end
  end

  // Word layout, last on top, then keep, then data
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      pk_word <= {user_tlast, user_tkeep, masked_data};
    end
  end

endmodule

`default_nettype wire

//--- verilog/link_online_delay.sv
`default_nettype none

// Link-up qualification
// Both online flags must stay high for delay_value + 1 cycles
module link_online_delay (
  input  logic        clk_wr,
  input  logic        arst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_value,
  output logic        link_up
);

  logic        both_online;
  logic [15:0] hold_cnt;
  logic        hold_done;

  assign both_online = tx_online & rx_online;

  // Count holds the edges already seen with both online
  // so it passes delay_value on edge delay_value + 1
  assign hold_done = hold_cnt > delay_value;

  //////////////////////////////
  // Hold-off counter
  //////////////////////////////
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      hold_cnt <= '0;
    end else if (!both_online) begin
      // Either side dropped, start over
      hold_cnt <= '0;
    end else if (hold_cnt != 16'hffff) begin
      // Saturate, no wrap back into the hold-off window
      hold_cnt <= hold_cnt + 16'd1;
    end
  end

  // Registered link status
  // Drops on the first edge after either side goes offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_up <= 1'b0;
    end else begin
      link_up <= both_online & hold_done;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ll_pkg.sv
`default_nettype none

// Link widths and bit layouts shared by the transmit blocks
package ll_pkg;

  //////////////////////////////
  // User stream
  //////////////////////////////
  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;

  // Link word, {tlast, keep, data} with data at the bottom
  localparam int WORD_W = 1 + KEEP_W + DATA_W;

  //////////////////////////////
  // PHY lanes
  //////////////////////////////
  localparam int LANE_W         = 40;
  localparam int LANE_PAYLOAD_W = 38;
  localparam int STB_BIT        = 39;
  localparam int MRK_BIT        = 38;
  // Both lanes of payload side by side
  localparam int PAYLOAD_W      = 2 * LANE_PAYLOAD_W;
  // Pushbit sits just above the word, two spare bits on top
  localparam int PUSH_BIT       = 73;
  // Credit return pulse on receive lane 0
  localparam int CREDIT_BIT     = 0;
  localparam int CREDIT_W       = 8;

  // Debug status fields
  localparam int DBG_W           = 32;
  localparam int DBG_CREDIT_LSB  = 0;
  localparam int DBG_LEVEL_LSB   = 8;
  localparam int DBG_LINK_UP_BIT = 16;

endpackage

`default_nettype wire
